/* rtl/control_config.svh */
// Memory wait count must be at least one and fit in WAIT_CNT_W bits
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

// Instruction register fields
`define OPCODE_W 6
`define FUNCT_W 6

// Fixed memory read latency in cycles
`define MEM_WAIT_CYCLES 2
`define WAIT_CNT_W 2

// Reset write of the stack pointer
`define SP_WRITE_IN 2'b10
`define SP_DATA_SRC 3'b110

// Memory address mux codes of the exception vectors
`define NEX_VECTOR_ADRS 2'b10
`define OVF_VECTOR_ADRS 2'b11

`endif

/* rtl/cpuControlPkg.sv */
// Mux codes in the control words follow the datapath and unlisted opcodes or functs trap
`default_nettype none

`include "control_config.svh"

package cpuControlPkg;

    typedef enum logic [`OPCODE_W-1:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opBle   = 6'h06,
        opBgt   = 6'h07,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opLui   = 6'h0f,
        opLb    = 6'h20,
        opLh    = 6'h21,
        opLw    = 6'h23,
        opSb    = 6'h28,
        opSh    = 6'h29,
        opSw    = 6'h2b
    } opcode_e;

    typedef enum logic [`FUNCT_W-1:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnSlt = 6'h2a
    } funct_e;

    typedef enum logic [5:0] {
        Reset1, Reset2, Fetch1, Fetch2, IrLoad, Decode1, Decode2,
        ExecArith, ExecImm, WriteRd, WriteRt, SetLess, SetLessImm, LoadUpper,
        Jump, JumpLink1, JumpLink2, JumpReg, Compare, BranchTaken,
        AddrCalc, MemWait, MdLoad, LoadWrite, Store,
        Exc1, Exc2, Exc3, Exc4
    } ctrlState_e;

    typedef enum logic [3:0] {
        clsArith, clsAddImm, clsSlt, clsSlti, clsLui, clsJ, clsJal, clsJr,
        clsBranch, clsLoad, clsStore, clsUnknown
    } instrClass_e;

    // Same order as the low opcode bits of the branches
    typedef enum logic [1:0] {brBeq, brBne, brBle, brBgt} branchKind_e;

    // Values double as the wdControl and mdControl codes
    typedef enum logic [1:0] {
        sizeWord = 2'b00,
        sizeHalf = 2'b01,
        sizeByte = 2'b10
    } accessSize_e;

    typedef enum logic [1:0] {arithAdd, arithSub, arithAnd} arithOp_e;

    typedef enum logic {causeOverflow, causeNonexistent} excCause_e;

    typedef struct packed {
        logic z;
        logic n;
        logic o;
        logic et;
        logic gt;
        logic lt;
    } aluFlags_t;

    typedef struct packed {
        logic       pcWrite;
        logic [2:0] pcSource;
    } pcCtrl_t;

    typedef struct packed {
        logic       memWrRd;
        logic [1:0] memAdrsSrc;
        logic [1:0] wdControl;
        logic       mdWrite;
        logic [1:0] mdControl;
    } memCtrl_t;

    typedef struct packed {
        logic       irWrite;
        logic [1:0] writeIn;
        logic [2:0] writeDataSrc;
        logic       regWrite;
        logic       abWrite;
    } regCtrl_t;

    typedef struct packed {
        logic [2:0] aluControl;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic       aluOutWrite;
        logic       epcWrite;
    } aluCtrl_t;

    typedef struct packed {
        instrClass_e instrClass;
        branchKind_e branchKind;
        accessSize_e accessSize;
        arithOp_e    arithOp;
    } decodeInfo_t;

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
// Combinational only and any encoding outside cpuControlPkg decodes as clsUnknown
`default_nettype none

`include "control_config.svh"

module instrDecoder
    import cpuControlPkg::*;
(
    input  logic [`OPCODE_W-1:0] Opcode,
    input  logic [`FUNCT_W-1:0]  Funct,
    output decodeInfo_t          decodeInfo
);

    always_comb begin
        decodeInfo = '{instrClass: clsUnknown, branchKind: brBeq,
                       accessSize: sizeWord, arithOp: arithAdd};
        case (Opcode)
            opRtype: begin
                case (Funct)
                    fnAdd: decodeInfo.instrClass = clsArith;
                    fnSub: begin
                        decodeInfo.instrClass = clsArith;
                        decodeInfo.arithOp    = arithSub;
                    end
                    fnAnd: begin
                        decodeInfo.instrClass = clsArith;
                        decodeInfo.arithOp    = arithAnd;
                    end
                    fnSlt:   decodeInfo.instrClass = clsSlt;
                    fnJr:    decodeInfo.instrClass = clsJr;
                    default: decodeInfo.instrClass = clsUnknown;
                endcase
            end
            opJ:   decodeInfo.instrClass = clsJ;
            opJal: decodeInfo.instrClass = clsJal;
            opBeq, opBne, opBle, opBgt: begin
                decodeInfo.instrClass = clsBranch;
                decodeInfo.branchKind = branchKind_e'(Opcode[1:0]);
            end
            opAddi, opAddiu: decodeInfo.instrClass = clsAddImm;
            opSlti:          decodeInfo.instrClass = clsSlti;
            opLui:           decodeInfo.instrClass = clsLui;
            opLb, opLh, opLw: begin
                decodeInfo.instrClass = clsLoad;
                decodeInfo.accessSize = (Opcode == opLb) ? sizeByte :
                                        (Opcode == opLh) ? sizeHalf : sizeWord;
            end
            opSb, opSh, opSw: begin
                decodeInfo.instrClass = clsStore;
                decodeInfo.accessSize = (Opcode == opSb) ? sizeByte :
                                        (Opcode == opSh) ? sizeHalf : sizeWord;
            end
            default: decodeInfo.instrClass = clsUnknown;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/controlSequencer.sv */
// Flags must be valid in the cycle of the ALU operation that the current state selects
`default_nettype none

`include "control_config.svh"

module controlSequencer
    import cpuControlPkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  decodeInfo_t          decodeInfo,
    input  logic [`OPCODE_W-1:0] Opcode,
    input  aluFlags_t            Flags,
    output ctrlState_e           state,
    output excCause_e            excCause
);

    localparam int waitLast = `MEM_WAIT_CYCLES - 1;

    ctrlState_e             nextState;
    logic [`WAIT_CNT_W-1:0] waitCnt;
    logic                   waitDone;
    logic                   branchTaken;

    assign waitDone = (waitCnt == waitLast[`WAIT_CNT_W-1:0]);

    always_comb begin
        case (decodeInfo.branchKind)
            brBeq:   branchTaken = Flags.et;
            brBne:   branchTaken = ~Flags.et;
            brBle:   branchTaken = Flags.lt | Flags.et;
            default: branchTaken = Flags.gt;
        endcase
    end

    always_comb begin
        case (state)
            Reset1:  nextState = Reset2;
            Reset2:  nextState = Fetch1;
            Fetch1:  nextState = Fetch2;
            Fetch2:  nextState = IrLoad;
            IrLoad:  nextState = Decode1;
            Decode1: nextState = Decode2;
            Decode2: begin
                case (decodeInfo.instrClass)
                    clsArith:  nextState = ExecArith;
                    clsAddImm: nextState = ExecImm;
                    clsSlt:    nextState = SetLess;
                    clsSlti:   nextState = SetLessImm;
                    clsLui:    nextState = LoadUpper;
                    clsJ:      nextState = Jump;
                    clsJal:    nextState = JumpLink1;
                    clsJr:     nextState = JumpReg;
                    clsBranch: nextState = Compare;
                    clsLoad, clsStore: nextState = AddrCalc;
                    default:   nextState = Exc1;
                endcase
            end
            ExecArith: nextState = Flags.o ? Exc1 : WriteRd;
            // addiu never traps
            ExecImm:   nextState = (Flags.o && Opcode == opAddi) ? Exc1 : WriteRt;
            JumpLink1: nextState = JumpLink2;
            Compare:   nextState = branchTaken ? BranchTaken : Fetch1;
            AddrCalc:  nextState = MemWait;
            MemWait:   nextState = waitDone ? MdLoad : MemWait;
            MdLoad:    nextState = (decodeInfo.instrClass == clsStore) ? Store : LoadWrite;
            Exc1:      nextState = Exc2;
            Exc2:      nextState = waitDone ? Exc3 : Exc2;
            Exc3:      nextState = Exc4;
            WriteRd, WriteRt, SetLess, SetLessImm, LoadUpper, Jump, JumpLink2,
            JumpReg, BranchTaken, LoadWrite, Store, Exc4: nextState = Fetch1;
            default:   nextState = Reset1;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            state    <= Reset1;
            waitCnt  <= '0;
            excCause <= causeOverflow;
        end else begin
            state <= nextState;
            // Restarts on every state change so each wait begins at zero
            if (nextState != state)
                waitCnt <= '0;
            else
                waitCnt <= waitCnt + 1'b1;
            // Only Decode2 jumps straight to Exc1 for an unknown instruction
            if (nextState == Exc1)
                excCause <= (state == Decode2) ? causeNonexistent : causeOverflow;
        end
    end

endmodule

`default_nettype wire

/* rtl/controlWordTable.sv */
// Moore outputs only and states without an entry drive the all-zero control word
`default_nettype none

`include "control_config.svh"

module controlWordTable
    import cpuControlPkg::*;
(
    input  ctrlState_e  state,
    input  decodeInfo_t decodeInfo,
    input  excCause_e   excCause,
    output pcCtrl_t     pcCtrl,
    output memCtrl_t    memCtrl,
    output regCtrl_t    regCtrl,
    output aluCtrl_t    aluCtrl
);

    logic [1:0] vectorAdrs;
    logic [2:0] arithAlu;

    assign vectorAdrs = (excCause == causeNonexistent) ? `NEX_VECTOR_ADRS : `OVF_VECTOR_ADRS;

    always_comb begin
        case (decodeInfo.arithOp)
            arithSub: arithAlu = 3'b010;
            arithAnd: arithAlu = 3'b011;
            default:  arithAlu = 3'b001;
        endcase
    end

    always_comb begin
        pcCtrl  = '0;
        memCtrl = '0;
        regCtrl = '0;
        aluCtrl = '0;
        // Reset1, Fetch1, Fetch2 and Decode2 keep the zero word
        case (state)
            Reset2: begin
                regCtrl.regWrite     = 1'b1;
                regCtrl.writeIn      = `SP_WRITE_IN;
                regCtrl.writeDataSrc = `SP_DATA_SRC;
            end
            IrLoad: begin
                regCtrl.irWrite    = 1'b1;
                // PC + 4
                pcCtrl             = '{pcWrite: 1'b1, pcSource: 3'b001};
                aluCtrl.aluControl = 3'b001;
                aluCtrl.aluSrcB    = 2'b01;
            end
            Decode1: begin
                // Branch target into ALUOut while A and B load
                regCtrl.abWrite     = 1'b1;
                aluCtrl.aluControl  = 3'b001;
                aluCtrl.aluSrcB     = 2'b11;
                aluCtrl.aluOutWrite = 1'b1;
            end
            ExecArith: begin
                aluCtrl = '{aluControl: arithAlu, aluSrcA: 2'b01, aluSrcB: 2'b00,
                            aluOutWrite: 1'b1, epcWrite: 1'b0};
            end
            ExecImm, AddrCalc: begin
                aluCtrl = '{aluControl: 3'b001, aluSrcA: 2'b01, aluSrcB: 2'b10,
                            aluOutWrite: 1'b1, epcWrite: 1'b0};
            end
            WriteRd: regCtrl = '{irWrite: 1'b0, writeIn: 2'b01, writeDataSrc: 3'b000,
                                 regWrite: 1'b1, abWrite: 1'b0};
            WriteRt: regCtrl = '{irWrite: 1'b0, writeIn: 2'b00, writeDataSrc: 3'b000,
                                 regWrite: 1'b1, abWrite: 1'b0};
            SetLess, SetLessImm: begin
                aluCtrl.aluControl   = 3'b111;
                aluCtrl.aluSrcA      = 2'b01;
                aluCtrl.aluSrcB      = (state == SetLessImm) ? 2'b10 : 2'b00;
                regCtrl.writeIn      = (state == SetLessImm) ? 2'b00 : 2'b01;
                regCtrl.writeDataSrc = 3'b111;
                regCtrl.regWrite     = 1'b1;
            end
            LoadUpper: begin
                regCtrl.writeDataSrc = 3'b010;
                regCtrl.regWrite     = 1'b1;
            end
            Jump: pcCtrl = '{pcWrite: 1'b1, pcSource: 3'b000};
            JumpLink1: begin
                // Return address passes through the ALU unchanged
                aluCtrl.aluOutWrite = 1'b1;
            end
            JumpLink2: begin
                pcCtrl               = '{pcWrite: 1'b1, pcSource: 3'b000};
                regCtrl.writeIn      = 2'b11;
                regCtrl.regWrite     = 1'b1;
            end
            JumpReg: begin
                pcCtrl          = '{pcWrite: 1'b1, pcSource: 3'b001};
                aluCtrl.aluSrcA = 2'b01;
            end
            Compare: begin
                aluCtrl.aluControl = 3'b111;
                aluCtrl.aluSrcA    = 2'b01;
            end
            BranchTaken: pcCtrl = '{pcWrite: 1'b1, pcSource: 3'b011};
            MemWait: memCtrl.memAdrsSrc = 2'b01;
            MdLoad: begin
                memCtrl.memAdrsSrc = 2'b01;
                memCtrl.mdWrite    = 1'b1;
            end
            LoadWrite: begin
                memCtrl.mdControl    = decodeInfo.accessSize;
                regCtrl.writeDataSrc = 3'b001;
                regCtrl.regWrite     = 1'b1;
            end
            Store: begin
                memCtrl.memWrRd    = 1'b1;
                memCtrl.memAdrsSrc = 2'b01;
                memCtrl.wdControl  = decodeInfo.accessSize;
            end
            Exc1: begin
                // EPC gets PC - 4
                aluCtrl = '{aluControl: 3'b010, aluSrcA: 2'b00, aluSrcB: 2'b01,
                            aluOutWrite: 1'b0, epcWrite: 1'b1};
            end
            Exc2: memCtrl.memAdrsSrc = vectorAdrs;
            Exc3: begin
                memCtrl.memAdrsSrc = vectorAdrs;
                memCtrl.mdWrite    = 1'b1;
            end
            Exc4: begin
                // Handler address is the byte read from the vector
                pcCtrl             = '{pcWrite: 1'b1, pcSource: 3'b100};
                memCtrl.memAdrsSrc = vectorAdrs;
                memCtrl.mdControl  = sizeByte;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/controlUnit.sv */
// No memory handshake so the datapath memory must answer within MEM_WAIT_CYCLES
`default_nettype none

`include "control_config.svh"

module controlUnit
    import cpuControlPkg::*;
(
    input  logic                 Clock,
    input  logic                 rst,
    input  logic [`OPCODE_W-1:0] Opcode,
    input  logic [`FUNCT_W-1:0]  Funct,
    input  aluFlags_t            Flags,
    output pcCtrl_t              pcCtrl,
    output memCtrl_t             memCtrl,
    output regCtrl_t             regCtrl,
    output aluCtrl_t             aluCtrl
);

    decodeInfo_t decodeInfo;
    ctrlState_e  state;
    excCause_e   excCause;

    instrDecoder decoder (
        .Opcode     (Opcode),
        .Funct      (Funct),
        .decodeInfo (decodeInfo)
    );

    controlSequencer sequencer (
        .Clock      (Clock),
        .rst        (rst),
        .decodeInfo (decodeInfo),
        .Opcode     (Opcode),
        .Flags      (Flags),
        .state      (state),
        .excCause   (excCause)
    );

    controlWordTable wordTable (
        .state      (state),
        .decodeInfo (decodeInfo),
        .excCause   (excCause),
        .pcCtrl     (pcCtrl),
        .memCtrl    (memCtrl),
        .regCtrl    (regCtrl),
        .aluCtrl    (aluCtrl)
    );

endmodule

`default_nettype wire

/* bench/clockGen.sv */
// Clock period is 4 time units and rst is released by a non-blocking write at the second edge
`default_nettype none

module clockGen (
    output logic Clock,
    output logic rst
);

    initial begin
        Clock = 1'b0;
        rst   = 1'b1;
        repeat (2) @(posedge Clock);
        rst <= 1'b0;
    end

    always #2 Clock = ~Clock;

endmodule

`default_nettype wire

/* bench/controlUnit_assertions.sv */
// Bound into controlUnit and assumes rst is high for at least one rising edge at start
`default_nettype none

module controlUnitAssertions
    import cpuControlPkg::*;
(
    input logic     Clock,
    input logic     rst,
    input pcCtrl_t  pcCtrl,
    input memCtrl_t memCtrl,
    input regCtrl_t regCtrl,
    input aluCtrl_t aluCtrl
);

    int         failCount = 0;
    logic       anyWrite;
    logic [2:0] sinceEpc;

    assign anyWrite = pcCtrl.pcWrite | memCtrl.memWrRd | memCtrl.mdWrite | regCtrl.irWrite |
                      regCtrl.regWrite | regCtrl.abWrite | aluCtrl.aluOutWrite |
                      aluCtrl.epcWrite;

    // Cycles since the last epcWrite, zero once pcWrite has followed
    always_ff @(posedge Clock) begin
        if (rst)
            sinceEpc <= '0;
        else if (aluCtrl.epcWrite)
            sinceEpc <= 3'd1;
        else if (pcCtrl.pcWrite)
            sinceEpc <= '0;
        else if (sinceEpc != '0)
            sinceEpc <= sinceEpc + 1'b1;
    end

    irWriteSingle: assert property (@(posedge Clock) disable iff (rst)
        regCtrl.irWrite |=> !regCtrl.irWrite)
    else begin
        failCount++;
        $error("irWrite high in two consecutive cycles");
    end

    regOrMemWrite: assert property (@(posedge Clock) disable iff (rst)
        !(regCtrl.regWrite && memCtrl.memWrRd))
    else begin
        failCount++;
        $error("regWrite and memWrRd high in the same cycle");
    end

    epcThenPc: assert property (@(posedge Clock) disable iff (rst)
        (sinceEpc == 3'd5) |-> pcCtrl.pcWrite)
    else begin
        failCount++;
        $error("epcWrite not followed by pcWrite within 5 cycles");
    end

    quietAfterReset: assert property (@(posedge Clock) rst |=> !anyWrite)
    else begin
        failCount++;
        $error("Write enable high in the cycle after reset");
    end

endmodule

`default_nettype wire

/* bench/controlUnitTb.sv */
// Run from the project root, and the first test data line must describe the reset window
`default_nettype none

`include "control_config.svh"

module controlUnitTb
    import cpuControlPkg::*;
();

    localparam logic [7:0] noValue = 8'h09;

    typedef struct packed {
        logic [7:0] cycles;
        logic [7:0] writeIn;
        logic [7:0] writeDataSrc;
        logic [7:0] mdControl;
        logic [7:0] regWrites;
        logic [7:0] pcSource;
        logic [7:0] vectorAdrs;
        logic [7:0] epcPulses;
        logic [7:0] wdControl;
        logic [7:0] memWrites;
    } results_t;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT_W-1:0]  funct;
        aluFlags_t            flags;
        results_t             expected;
    } testVec_t;

    logic                 Clock;
    logic                 rst;
    logic [`OPCODE_W-1:0] Opcode;
    logic [`FUNCT_W-1:0]  Funct;
    aluFlags_t            Flags;
    pcCtrl_t              pcCtrl;
    memCtrl_t             memCtrl;
    regCtrl_t             regCtrl;
    aluCtrl_t             aluCtrl;
    string                testNames[$];
    testVec_t             tests[$];
    int                   mismatchCount = 0;
    int                   otherCount = 0;
    int                   cycleCount = 0;
    int                   cycleLimit = 0;

    clockGen clocks (
        .Clock (Clock),
        .rst   (rst)
    );

    controlUnit UUT (
        .Clock   (Clock),
        .rst     (rst),
        .Opcode  (Opcode),
        .Funct   (Funct),
        .Flags   (Flags),
        .pcCtrl  (pcCtrl),
        .memCtrl (memCtrl),
        .regCtrl (regCtrl),
        .aluCtrl (aluCtrl)
    );

    bind controlUnit controlUnitAssertions checks (
        .Clock   (Clock),
        .rst     (rst),
        .pcCtrl  (pcCtrl),
        .memCtrl (memCtrl),
        .regCtrl (regCtrl),
        .aluCtrl (aluCtrl)
    );

    task automatic reportCounts();
        $display("Mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 mismatchCount, otherCount, UUT.checks.failCount);
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles without finishing the tests", cycleCount);
            reportCounts();
            $display("tests failed");
            $finish;
        end
    end

    task automatic loadTests();
        int       fd;
        int       fields;
        int       col [11];
        string    line;
        string    name;
        testVec_t vec;
        fd = $fopen("bench/controlUnit_testdata.txt", "r");
        if (fd == 0) begin
            otherCount++;
            $display("Cannot open bench/controlUnit_testdata.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            fields = $sscanf(line, "%s %h %h %h %d %h %h %h %h %h %d %h", name,
                             col[0], col[1], col[2], col[3], col[4], col[5],
                             col[6], col[7], col[8], col[9], col[10]);
            if (fields != 12) begin
                otherCount++;
                $display("Test data line could not be parsed: %s", line);
                continue;
            end
            vec.opcode                = col[0][`OPCODE_W-1:0];
            vec.funct                 = col[1][`FUNCT_W-1:0];
            vec.flags                 = col[2][5:0];
            vec.expected.cycles       = col[3][7:0];
            vec.expected.writeIn      = col[4][7:0];
            vec.expected.writeDataSrc = col[5][7:0];
            vec.expected.mdControl    = col[6][7:0];
            vec.expected.pcSource     = col[7][7:0];
            vec.expected.vectorAdrs   = col[8][7:0];
            vec.expected.epcPulses    = col[9][7:0];
            vec.expected.wdControl    = col[10][7:0];
            // One register write unless none is given, and one memory write per store
            vec.expected.regWrites = (col[4][7:0] == noValue) ? 8'd0 : 8'd1;
            vec.expected.memWrites = (col[10][7:0] == noValue) ? 8'd0 : 8'd1;
            testNames.push_back(name);
            tests.push_back(vec);
        end
        $fclose(fd);
    endtask

    // Starts at a falling edge and stops at the falling edge of the next IrLoad
    task automatic measure(input logic [7:0] firstCycles, output results_t seen);
        seen           = '{default: noValue};
        seen.cycles    = firstCycles;
        seen.regWrites = 8'd0;
        seen.epcPulses = 8'd0;
        seen.memWrites = 8'd0;
        while (!regCtrl.irWrite) begin
            seen.cycles++;
            if (regCtrl.regWrite) begin
                seen.regWrites++;
                seen.writeIn      = {6'd0, regCtrl.writeIn};
                seen.writeDataSrc = {5'd0, regCtrl.writeDataSrc};
                seen.mdControl    = {6'd0, memCtrl.mdControl};
            end
            if (pcCtrl.pcWrite) begin
                seen.pcSource   = {5'd0, pcCtrl.pcSource};
                seen.vectorAdrs = {6'd0, memCtrl.memAdrsSrc};
            end
            if (memCtrl.memWrRd) begin
                seen.memWrites++;
                seen.wdControl = {6'd0, memCtrl.wdControl};
            end
            if (aluCtrl.epcWrite)
                seen.epcPulses++;
            @(negedge Clock);
        end
    endtask

    task automatic compareField(input string testName, input string field,
                                input logic [7:0] expected, input logic [7:0] actual);
        assert (expected == actual)
        else begin
            mismatchCount++;
            $display("Mismatch %s %s: expected %0d, actual %0d",
                     testName, field, expected, actual);
        end
    endtask

    task automatic checkResults(input string testName, input results_t expected,
                                input results_t seen);
        compareField(testName, "cycles", expected.cycles, seen.cycles);
        compareField(testName, "regWrite pulses", expected.regWrites, seen.regWrites);
        compareField(testName, "writeIn", expected.writeIn, seen.writeIn);
        compareField(testName, "writeDataSrc", expected.writeDataSrc, seen.writeDataSrc);
        compareField(testName, "mdControl", expected.mdControl, seen.mdControl);
        compareField(testName, "pcSource", expected.pcSource, seen.pcSource);
        compareField(testName, "memAdrsSrc", expected.vectorAdrs, seen.vectorAdrs);
        compareField(testName, "epcWrite pulses", expected.epcPulses, seen.epcPulses);
        compareField(testName, "memWrRd pulses", expected.memWrites, seen.memWrites);
        compareField(testName, "wdControl", expected.wdControl, seen.wdControl);
    endtask

    initial begin
        results_t seen;
        Opcode = '0;
        Funct  = '0;
        Flags  = '0;
        loadTests();
        cycleLimit = 12 * tests.size() + 10;
        if (tests.size() == 0) begin
            otherCount++;
            $display("No tests were read from the test data file");
        end else begin
            @(negedge Clock);
            while (rst)
                @(negedge Clock);
            measure(8'd0, seen);
            checkResults(testNames[0], tests[0].expected, seen);
            for (int i = 1; i < tests.size(); i++) begin
                // Next instruction enters in the cycle after the irWrite pulse
                @(posedge Clock);
                Opcode <= tests[i].opcode;
                Funct  <= tests[i].funct;
                Flags  <= tests[i].flags;
                @(negedge Clock);
                measure(8'd1, seen);
                checkResults(testNames[i], tests[i].expected, seen);
            end
        end
        reportCounts();
        if (mismatchCount + otherCount + UUT.checks.failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/controlUnit_testdata.txt */
# name opcode funct flags cycles writeIn writeDataSrc mdControl pcSource memAdrsSrc epcPulses wdControl
# Hex except cycles and epcPulses, flags are z n o et gt lt from bit 5 down, 9 means none
reset      00 00 00  4 2 6 0 9 9 0 9
add        00 20 00  7 1 0 0 9 9 0 9
sub        00 22 00  7 1 0 0 9 9 0 9
and        00 24 00  7 1 0 0 9 9 0 9
slt        00 2a 00  6 1 7 0 9 9 0 9
addi       08 00 00  7 0 0 0 9 9 0 9
addiu_ovf  09 00 08  7 0 0 0 9 9 0 9
slti       0a 00 00  6 0 7 0 9 9 0 9
lui        0f 00 00  6 0 2 0 9 9 0 9
j          02 00 00  6 9 9 9 0 0 0 9
jal        03 00 00  7 3 0 0 0 0 0 9
jr         00 08 00  6 9 9 9 1 0 0 9
beq_taken  04 00 04  7 9 9 9 3 0 0 9
beq_not    04 00 00  6 9 9 9 9 9 0 9
bne_taken  05 00 00  7 9 9 9 3 0 0 9
bne_not    05 00 04  6 9 9 9 9 9 0 9
ble_taken  06 00 01  7 9 9 9 3 0 0 9
ble_not    06 00 02  6 9 9 9 9 9 0 9
bgt_taken  07 00 02  7 9 9 9 3 0 0 9
bgt_not    07 00 01  6 9 9 9 9 9 0 9
lw         23 00 00 10 0 1 0 9 9 0 9
lh         21 00 00 10 0 1 1 9 9 0 9
lb         20 00 00 10 0 1 2 9 9 0 9
sw         2b 00 00 10 9 9 9 9 9 0 0
sh         29 00 00 10 9 9 9 9 9 0 1
sb         28 00 00 10 9 9 9 9 9 0 2
add_ovf    00 20 08 11 9 9 9 4 3 1 9
addi_ovf   08 00 08 11 9 9 9 4 3 1 9
bad_opcode 3f 00 00 10 9 9 9 4 2 1 9
bad_funct  00 00 00 10 9 9 9 4 2 1 9

/* filelist.f */
+incdir+rtl
rtl/cpuControlPkg.sv
rtl/instrDecoder.sv
rtl/controlSequencer.sv
rtl/controlWordTable.sv
rtl/controlUnit.sv
bench/clockGen.sv
bench/controlUnit_assertions.sv
bench/controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the control unit testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module controlUnitTb \
    -Mdir obj_dir -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
./obj_dir/controlUnitSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    exit 1
fi
exit 0
